// File: icache_defines.svh
// geometry macros: pc and instruction widths, line layout, set count, tag width, fetch width

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

//////////////////////////////////////////////////
// core widths
//////////////////////////////////////////////////

`define SIZE_PC                      32
`define SIZE_INSTRUCTION             32

// byte offset inside one instruction word
`define ICACHE_INST_BYTE_OFFSET_LOG  2

//////////////////////////////////////////////////
// line and cache geometry
//////////////////////////////////////////////////

// instruction slot inside a line
`define ICACHE_OFFSET_BITS           2
`define ICACHE_INSTS_IN_LINE         4
`define ICACHE_BITS_IN_LINE          128

// 64 sets, two ways each
`define ICACHE_INDEX_BITS            6
`define ICACHE_NUM_LINES             64
`define ICACHE_TAG_BITS              22
`define ICACHE_NUM_WAYS              2

// instructions handed to fetch per access
`define FETCH_WIDTH                  2

`endif

// File: icache_addr_pkg.sv
// address types: fetch pc, tag, set index, line offset and block address

`include "icache_defines.svh"

package icache_addr_pkg;

  //////////////////////////////////////////////////
  // pc layout
  //////////////////////////////////////////////////

  // tag | index | offset | byte
  // 31..10 | 9..4 | 3..2 | 1..0

  // full fetch address
  typedef logic [`SIZE_PC-1:0] pc_t;

  // upper pc bits compared against the tag stores
  typedef logic [`ICACHE_TAG_BITS-1:0] ic_tag_t;

  // set select
  typedef logic [`ICACHE_INDEX_BITS-1:0] ic_index_t;

  // first instruction slot of the access
  typedef logic [`ICACHE_OFFSET_BITS-1:0] ic_offset_t;

  //////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////

  // line address sent to memory, tag in the upper bits
  typedef logic [`ICACHE_TAG_BITS+`ICACHE_INDEX_BITS-1:0] ic_block_addr_t;

endpackage

// File: icache_line_pkg.sv
// line types: instruction word, cache line, way number and fetch slot vector

`include "icache_defines.svh"

package icache_line_pkg;

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // one instruction word
  typedef logic [`SIZE_INSTRUCTION-1:0] inst_t;

  // one cache line
  // slot 0 sits in bits 31..0, slot 3 in bits 127..96
  typedef logic [`ICACHE_BITS_IN_LINE-1:0] ic_line_t;

  //////////////////////////////////////////////////
  // way and slot bookkeeping
  //////////////////////////////////////////////////

  // way number, one bit for a two-way cache
  typedef logic [$clog2(`ICACHE_NUM_WAYS)-1:0] ic_way_t;

  // per-slot valid flags toward fetch
  // bit 0 is the instruction at the pc itself
  typedef logic [`FETCH_WIDTH-1:0] ic_slot_vec_t;

endpackage

// File: line_store.sv
// line_store: one-way storage array with asynchronous read and clocked write

`timescale 1ns/1ps

`include "icache_defines.svh"

module line_store
  import icache_addr_pkg::*;
#(
  parameter type ENTRY_T = logic
) (
  input  logic      clk,
  input  logic      reset,

  // lookup side
  input  ic_index_t rd_index_i,
  output ENTRY_T    rd_entry_o,

  // fill side
  input  logic      wr_en_i,
  input  ic_index_t wr_index_i,
  input  ENTRY_T    wr_entry_i
);

  // one entry per set
  ENTRY_T mem_q [`ICACHE_NUM_LINES];

  // read is combinational so the lookup resolves in the same cycle
  assign rd_entry_o = mem_q[rd_index_i];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `ICACHE_NUM_LINES; i++)
        mem_q[i] <= '0;
    end
    else if (wr_en_i)
    begin
      mem_q[wr_index_i] <= wr_entry_i;
    end
  end

endmodule

// File: valid_bits.sv
// valid_bits: per-set per-way valid flags with flush, invalidation, fill and flush-done

`timescale 1ns/1ps

`include "icache_defines.svh"

module valid_bits
  import icache_addr_pkg::*;
  import icache_line_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,

  // lookup read
  input  ic_index_t                   rd_index_i,
  output logic [`ICACHE_NUM_WAYS-1:0] valid_o,

  // fill from the miss handler
  input  logic                        fill_en_i,
  input  ic_index_t                   fill_index_i,
  input  ic_way_t                     fill_way_i,

  // single-line invalidation from memory
  input  logic                        inv_i,
  input  ic_index_t                   inv_index_i,
  input  ic_way_t                     inv_way_i,

  // whole-cache flush
  input  logic                        flush_i,
  output logic                        flush_done_o
);

  // bit w of entry s: way w of set s holds a line
  logic [`ICACHE_NUM_WAYS-1:0] valid_q [`ICACHE_NUM_LINES];

  assign valid_o = valid_q[rd_index_i];

  //////////////////////////////////////////////////
  // flag update
  //////////////////////////////////////////////////

  // priority: flush, then invalidation, then fill
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `ICACHE_NUM_LINES; i++)
        valid_q[i] <= '0;
    end
    else if (flush_i)
    begin
      for (int i = 0; i < `ICACHE_NUM_LINES; i++)
        valid_q[i] <= '0;
    end
    else if (inv_i)
    begin
      // only the named way drops, the other way of the set stays
      valid_q[inv_index_i][inv_way_i] <= 1'b0;
    end
    else if (fill_en_i)
    begin
      valid_q[fill_index_i][fill_way_i] <= 1'b1;
    end
  end

  // done one cycle after the flush request
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      flush_done_o <= 1'b0;
    else
      flush_done_o <= flush_i;
  end

endmodule

// File: way_lookup.sv
// way_lookup: pc split, tag compare in both ways, hit select, instruction extraction

`timescale 1ns/1ps

`include "icache_defines.svh"

module way_lookup
  import icache_addr_pkg::*;
  import icache_line_pkg::*;
(
  // fetch request
  input  logic                        fetch_req_i,
  input  pc_t                         pc_i,

  // store read port
  output ic_index_t                   rd_index_o,
  input  ic_tag_t                     tag0_i,
  input  ic_tag_t                     tag1_i,
  input  ic_line_t                    line0_i,
  input  ic_line_t                    line1_i,
  input  logic [`ICACHE_NUM_WAYS-1:0] valid_i,

  // back to fetch
  output inst_t                       inst_o [`FETCH_WIDTH],
  output ic_slot_vec_t                inst_valid_o,

  // toward the miss handler
  output logic                        miss_o,
  output ic_tag_t                     pc_tag_o,
  output ic_offset_t                  pc_offset_o
);

  // slot number wide enough to run past the end of the line
  typedef logic [`ICACHE_OFFSET_BITS:0] slot_idx_t;

  logic     hit0;
  logic     hit1;
  logic     hit;
  ic_line_t hit_line;

  //////////////////////////////////////////////////
  // pc fields
  //////////////////////////////////////////////////

  assign pc_offset_o = pc_i[`ICACHE_OFFSET_BITS+`ICACHE_INST_BYTE_OFFSET_LOG-1 :
                            `ICACHE_INST_BYTE_OFFSET_LOG];
  assign rd_index_o  = pc_i[`ICACHE_INDEX_BITS+`ICACHE_OFFSET_BITS+`ICACHE_INST_BYTE_OFFSET_LOG-1 :
                            `ICACHE_OFFSET_BITS+`ICACHE_INST_BYTE_OFFSET_LOG];
  assign pc_tag_o    = pc_i[`SIZE_PC-1 :
                            `ICACHE_INDEX_BITS+`ICACHE_OFFSET_BITS+`ICACHE_INST_BYTE_OFFSET_LOG];

  //////////////////////////////////////////////////
  // hit detection
  //////////////////////////////////////////////////

  // a way only hits while fetch is asking
  assign hit0 = fetch_req_i & valid_i[0] & (tag0_i == pc_tag_o);
  assign hit1 = fetch_req_i & valid_i[1] & (tag1_i == pc_tag_o);
  assign hit  = hit0 | hit1;

  // way 0 wins if both ever match
  assign hit_line = hit0 ? line0_i : line1_i;

  // no bypass, fetch replays until slot 0 comes back valid
  assign miss_o = fetch_req_i & ~hit;

  //////////////////////////////////////////////////
  // instruction extraction
  //////////////////////////////////////////////////

  always_comb
  begin
    slot_idx_t slot;
    inst_valid_o = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++)
    begin
      slot      = slot_idx_t'(pc_offset_o) + slot_idx_t'(i);
      inst_o[i] = '0;
      // slots past the line end stay empty, fetch picks them up next line
      if (slot < `ICACHE_INSTS_IN_LINE)
      begin
        inst_o[i] = hit_line[slot[`ICACHE_OFFSET_BITS-1:0]*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION];
        inst_valid_o[i] = hit;
      end
    end
  end

endmodule

// File: miss_handler.sv
// miss_handler: miss pulse, single MSHR, memory request, round-robin victims, registered fill

`timescale 1ns/1ps

`include "icache_defines.svh"

module miss_handler
  import icache_addr_pkg::*;
  import icache_line_pkg::*;
(
  input  logic           clk,
  input  logic           reset,

  // from the lookup
  input  logic           fetch_req_i,
  input  logic           miss_i,
  input  ic_tag_t        pc_tag_i,
  input  ic_index_t      pc_index_i,

  // line request to memory
  output logic           req_valid_o,
  output ic_block_addr_t req_addr_o,

  // tagged response from memory
  input  logic           resp_valid_i,
  input  ic_tag_t        resp_tag_i,
  input  ic_index_t      resp_index_i,
  input  ic_line_t       resp_data_i,

  // fill write toward the stores and valid flags
  output logic           fill_en_o,
  output ic_index_t      fill_index_o,
  output ic_way_t        fill_way_o,
  output ic_tag_t        fill_tag_o,
  output ic_line_t       fill_line_o
);

  // miss history for the one-shot pulse
  logic      miss_d1;
  logic      miss_d2;
  logic      miss_pulse;

  // pc fields of the missing access, one cycle late
  ic_tag_t   pc_tag_q;
  ic_index_t pc_index_q;

  // the MSHR
  logic      mshr_valid;
  ic_tag_t   mshr_tag;
  ic_index_t mshr_index;
  ic_way_t   mshr_way;
  logic      resp_match;

  // victim pointer per set
  ic_way_t   rr_q [`ICACHE_NUM_LINES];

  //////////////////////////////////////////////////
  // miss pulse
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      // fill drops the history so a still-pending miss pulses again
      miss_d1 <= miss_i & fetch_req_i & ~fill_en_o;
      miss_d2 <= miss_d1 & ~fill_en_o;
    end
  end

  assign miss_pulse = miss_d1 & ~miss_d2;

  always_ff @(posedge clk)
  begin
    pc_tag_q   <= pc_tag_i;
    pc_index_q <= pc_index_i;
  end

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // issue only with a free MSHR or one that frees this cycle
  // otherwise the pulse is dropped and fetch replays
  assign req_valid_o = miss_pulse & (~mshr_valid | fill_en_o);
  assign req_addr_o  = {pc_tag_q, pc_index_q};

  // pointer moves only when a request for that set goes out
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `ICACHE_NUM_LINES; i++)
        rr_q[i] <= '0;
    end
    else if (req_valid_o)
    begin
      rr_q[pc_index_q] <= ~rr_q[pc_index_q];
    end
  end

  //////////////////////////////////////////////////
  // MSHR
  //////////////////////////////////////////////////

  assign resp_match = resp_valid_i & mshr_valid &
                      (resp_tag_i == mshr_tag) & (resp_index_i == mshr_index);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mshr_valid <= 1'b0;
    else if (req_valid_o)
      mshr_valid <= 1'b1;
    else if (resp_match)
      mshr_valid <= 1'b0;
  end

  // address and victim way are captured with the request
  always_ff @(posedge clk)
  begin
    if (req_valid_o)
    begin
      mshr_tag   <= pc_tag_q;
      mshr_index <= pc_index_q;
      mshr_way   <= rr_q[pc_index_q];
    end
  end

  //////////////////////////////////////////////////
  // registered fill
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fill_en_o <= 1'b0;
    else
      fill_en_o <= resp_match;
  end

  // fill goes into the victim way recorded at request time
  always_ff @(posedge clk)
  begin
    fill_index_o <= mshr_index;
    fill_way_o   <= mshr_way;
    fill_tag_o   <= mshr_tag;
    fill_line_o  <= resp_data_i;
  end

endmodule

// File: icache_top.sv
// icache_top: two-way instruction cache, stores, valid flags, lookup and miss handler

`timescale 1ns/1ps

`include "icache_defines.svh"

module icache_top
  import icache_addr_pkg::*;
  import icache_line_pkg::*;
(
  input  logic           clk,
  input  logic           reset,

  // fetch side
  input  logic           fetchReq_i,
  input  pc_t            pc_i,
  output inst_t          inst_o [`FETCH_WIDTH],
  output ic_slot_vec_t   instValid_o,
  output logic           icMiss_o,

  // line request
  output ic_block_addr_t ic2memReqAddr_o,
  output logic           ic2memReqValid_o,

  // line response
  input  ic_tag_t        mem2icTag_i,
  input  ic_index_t      mem2icIndex_i,
  input  ic_line_t       mem2icData_i,
  input  logic           mem2icRespValid_i,

  // invalidation and flush
  input  logic           mem2icInv_i,
  input  ic_index_t      mem2icInvInd_i,
  input  ic_way_t        mem2icInvWay_i,
  input  logic           icFlush_i,
  output logic           icFlushDone_o
);

  // lookup read path
  ic_index_t                   rd_index;
  ic_tag_t                     tag0;
  ic_tag_t                     tag1;
  ic_line_t                    line0;
  ic_line_t                    line1;
  logic [`ICACHE_NUM_WAYS-1:0] way_valid;

  // lookup to miss handler
  logic                        miss;
  ic_tag_t                     pc_tag;

  // fill write path
  logic                        fill_en;
  ic_index_t                   fill_index;
  ic_way_t                     fill_way;
  ic_tag_t                     fill_tag;
  ic_line_t                    fill_line;
  logic                        fill_en0;
  logic                        fill_en1;

  // the request pulse doubles as the miss indication
  assign icMiss_o = ic2memReqValid_o;

  // steer the fill to the victim way
  assign fill_en0 = fill_en & (fill_way == ic_way_t'(0));
  assign fill_en1 = fill_en & (fill_way == ic_way_t'(1));

  //////////////////////////////////////////////////
  // way 0 and way 1 stores
  //////////////////////////////////////////////////

  line_store #(.ENTRY_T(ic_line_t)) u_data0 (
    .clk        (clk),
    .reset      (reset),
    .rd_index_i (rd_index),
    .rd_entry_o (line0),
    .wr_en_i    (fill_en0),
    .wr_index_i (fill_index),
    .wr_entry_i (fill_line)
  );

  line_store #(.ENTRY_T(ic_tag_t)) u_tag0 (
    .clk        (clk),
    .reset      (reset),
    .rd_index_i (rd_index),
    .rd_entry_o (tag0),
    .wr_en_i    (fill_en0),
    .wr_index_i (fill_index),
    .wr_entry_i (fill_tag)
  );

  line_store #(.ENTRY_T(ic_line_t)) u_data1 (
    .clk        (clk),
    .reset      (reset),
    .rd_index_i (rd_index),
    .rd_entry_o (line1),
    .wr_en_i    (fill_en1),
    .wr_index_i (fill_index),
    .wr_entry_i (fill_line)
  );

  line_store #(.ENTRY_T(ic_tag_t)) u_tag1 (
    .clk        (clk),
    .reset      (reset),
    .rd_index_i (rd_index),
    .rd_entry_o (tag1),
    .wr_en_i    (fill_en1),
    .wr_index_i (fill_index),
    .wr_entry_i (fill_tag)
  );

  valid_bits u_valid (
    .clk          (clk),
    .reset        (reset),
    .rd_index_i   (rd_index),
    .valid_o      (way_valid),
    .fill_en_i    (fill_en),
    .fill_index_i (fill_index),
    .fill_way_i   (fill_way),
    .inv_i        (mem2icInv_i),
    .inv_index_i  (mem2icInvInd_i),
    .inv_way_i    (mem2icInvWay_i),
    .flush_i      (icFlush_i),
    .flush_done_o (icFlushDone_o)
  );

  //////////////////////////////////////////////////
  // lookup and miss handling
  //////////////////////////////////////////////////

  // offset stays inside the lookup, the MSHR tracks whole lines
  way_lookup u_lookup (
    .fetch_req_i  (fetchReq_i),
    .pc_i         (pc_i),
    .rd_index_o   (rd_index),
    .tag0_i       (tag0),
    .tag1_i       (tag1),
    .line0_i      (line0),
    .line1_i      (line1),
    .valid_i      (way_valid),
    .inst_o       (inst_o),
    .inst_valid_o (instValid_o),
    .miss_o       (miss),
    .pc_tag_o     (pc_tag),
    .pc_offset_o  ()
  );

  miss_handler u_miss (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetchReq_i),
    .miss_i       (miss),
    .pc_tag_i     (pc_tag),
    .pc_index_i   (rd_index),
    .req_valid_o  (ic2memReqValid_o),
    .req_addr_o   (ic2memReqAddr_o),
    .resp_valid_i (mem2icRespValid_i),
    .resp_tag_i   (mem2icTag_i),
    .resp_index_i (mem2icIndex_i),
    .resp_data_i  (mem2icData_i),
    .fill_en_o    (fill_en),
    .fill_index_o (fill_index),
    .fill_way_o   (fill_way),
    .fill_tag_o   (fill_tag),
    .fill_line_o  (fill_line)
  );

endmodule

// File: tb_icache_top.sv
// testbench with clock, reset, memory response model, line scoreboard and checks

`timescale 1ns/1ps

`include "icache_defines.svh"

module tb_icache_top
  import icache_addr_pkg::*;
  import icache_line_pkg::*;
();

  // DUT inputs
  logic           clk;
  logic           reset;
  logic           fetchReq_i;
  pc_t            pc_i;
  ic_tag_t        mem2icTag_i;
  ic_index_t      mem2icIndex_i;
  ic_line_t       mem2icData_i;
  logic           mem2icRespValid_i;
  logic           mem2icInv_i;
  ic_index_t      mem2icInvInd_i;
  ic_way_t        mem2icInvWay_i;
  logic           icFlush_i;

  // DUT outputs
  inst_t          inst_o [`FETCH_WIDTH];
  ic_slot_vec_t   instValid_o;
  logic           icMiss_o;
  ic_block_addr_t ic2memReqAddr_o;
  logic           ic2memReqValid_o;
  logic           icFlushDone_o;

  // scoreboard of cached lines per set and way
  ic_tag_t        exp_tag   [`ICACHE_NUM_LINES][`ICACHE_NUM_WAYS];
  logic           exp_valid [`ICACHE_NUM_LINES][`ICACHE_NUM_WAYS];
  ic_way_t        exp_rr    [`ICACHE_NUM_LINES];

  // bookkeeping shared between the memory model and the stimulus
  int             cycle;
  int             req_count;
  int             miss_count;
  int             resp_edge;
  logic           good_resp_sent;
  logic           send_bad;
  logic           flush_prev;
  int unsigned    seed_dummy;

  icache_top UUT (
    .clk               (clk),
    .reset             (reset),
    .fetchReq_i        (fetchReq_i),
    .pc_i              (pc_i),
    .inst_o            (inst_o),
    .instValid_o       (instValid_o),
    .icMiss_o          (icMiss_o),
    .ic2memReqAddr_o   (ic2memReqAddr_o),
    .ic2memReqValid_o  (ic2memReqValid_o),
    .mem2icTag_i       (mem2icTag_i),
    .mem2icIndex_i     (mem2icIndex_i),
    .mem2icData_i      (mem2icData_i),
    .mem2icRespValid_i (mem2icRespValid_i),
    .mem2icInv_i       (mem2icInv_i),
    .mem2icInvInd_i    (mem2icInvInd_i),
    .mem2icInvWay_i    (mem2icInvWay_i),
    .icFlush_i         (icFlush_i),
    .icFlushDone_o     (icFlushDone_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////

  task automatic halt_failed(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    assert (got === exp)
    else
    begin
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
      halt_failed("value check failed");
    end
  endtask

  task automatic require(input logic cond, input string msg);
    assert (cond === 1'b1)
    else
      halt_failed(msg);
  endtask

  //////////////////////////////////////////////////
  // memory contents
  //////////////////////////////////////////////////

  // slot k of a block mixes block address, slot number and a fixed pattern
  function automatic inst_t model_word(input ic_block_addr_t blk, input logic [1:0] k);
    return {blk, k, 2'b01} ^ 32'h5a5a_0000;
  endfunction

  function automatic ic_line_t model_line(input ic_block_addr_t blk);
    ic_line_t line;
    for (int k = 0; k < `ICACHE_INSTS_IN_LINE; k++)
      line[k*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION] = model_word(blk, k[1:0]);
    return line;
  endfunction

  function automatic pc_t make_pc(input ic_tag_t t, input ic_index_t i, input ic_offset_t o);
    return {t, i, o, 2'b00};
  endfunction

  //////////////////////////////////////////////////
  // memory response model
  //////////////////////////////////////////////////

  // one response pulse after a random delay of 1 to 6 cycles
  task automatic respond(input ic_block_addr_t blk, input logic good);
    int delay;
    delay = 1 + ($urandom % 6);
    repeat (delay)
    begin
      @(posedge clk);
      mem2icRespValid_i <= 1'b0;
    end
    mem2icRespValid_i <= 1'b1;
    mem2icTag_i       <= blk[`ICACHE_TAG_BITS+`ICACHE_INDEX_BITS-1:`ICACHE_INDEX_BITS];
    mem2icIndex_i     <= blk[`ICACHE_INDEX_BITS-1:0];
    mem2icData_i      <= model_line(blk);
    if (good)
    begin
      good_resp_sent = 1'b1;
      // sampled by the DUT at the following edge
      resp_edge = cycle + 2;
    end
  endtask

  initial
  begin
    ic_block_addr_t blk;
    seed_dummy = $urandom(32'he4dab406);
    forever
    begin
      @(posedge clk);
      mem2icRespValid_i <= 1'b0;
      if (!reset && ic2memReqValid_o)
      begin
        blk = ic2memReqAddr_o;
        if (send_bad)
        begin
          send_bad = 1'b0;
          // wrong tag first, then wrong index
          respond(blk ^ (28'h1 << `ICACHE_INDEX_BITS), 1'b0);
          respond(blk ^ 28'h1, 1'b0);
        end
        respond(blk, 1'b1);
      end
    end
  end

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle      <= cycle + 1;
    flush_prev <= reset ? 1'b0 : icFlush_i;
    if (!reset && ic2memReqValid_o)
      req_count <= req_count + 1;
    if (!reset && icMiss_o)
      miss_count <= miss_count + 1;
  end

  // checked mid-cycle away from the driving edge
  always @(negedge clk)
  begin
    if (!reset)
      compare_value("icFlushDone_o", icFlushDone_o, flush_prev);
  end

  initial
  begin
    repeat (20000) @(posedge clk);
    halt_failed("watchdog expired before the test sequence finished");
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  // held fetch until slot 0 hits with request and data checks
  task automatic fetch_pc(input pc_t pc_v);
    ic_tag_t    tag;
    ic_index_t  idx;
    ic_offset_t off;
    logic       exp_hit;
    ic_way_t    victim;
    int         start_count;
    int         start_miss;
    int         waited;
    int         slot;
    tag = pc_v[`SIZE_PC-1:`SIZE_PC-`ICACHE_TAG_BITS];
    idx = pc_v[9:4];
    off = pc_v[3:2];
    exp_hit = (exp_valid[idx][0] && exp_tag[idx][0] == tag) ||
              (exp_valid[idx][1] && exp_tag[idx][1] == tag);
    start_count    = req_count;
    start_miss     = miss_count;
    good_resp_sent = 1'b0;
    @(posedge clk);
    fetchReq_i <= 1'b1;
    pc_i       <= pc_v;
    @(negedge clk);
    compare_value("instValid_o[0]", instValid_o[0], exp_hit);
    if (!exp_hit)
    begin
      compare_value("instValid_o", instValid_o, '0);
      compare_value("ic2memReqValid_o", ic2memReqValid_o, 1'b0);
      compare_value("icMiss_o", icMiss_o, 1'b0);
      // pulse in the cycle after the first missing edge
      @(negedge clk);
      compare_value("ic2memReqValid_o", ic2memReqValid_o, 1'b1);
      compare_value("icMiss_o", icMiss_o, 1'b1);
      compare_value("ic2memReqAddr_o", ic2memReqAddr_o, {tag, idx});
      victim      = exp_rr[idx];
      exp_rr[idx] = ~exp_rr[idx];
      waited = 0;
      while (!instValid_o[0] && waited < 60)
      begin
        @(negedge clk);
        waited++;
      end
      require(instValid_o[0], "fetch never hit after the line request");
      require(good_resp_sent, "fetch hit before the matching response arrived");
      compare_value("first hit cycle", cycle, resp_edge + 1);
      compare_value("request pulses", req_count - start_count, 1);
      compare_value("miss pulses", miss_count - start_miss, 1);
      exp_tag[idx][victim]   = tag;
      exp_valid[idx][victim] = 1'b1;
    end
    for (int i = 0; i < `FETCH_WIDTH; i++)
    begin
      slot = off + i;
      if (slot < `ICACHE_INSTS_IN_LINE)
      begin
        compare_value("instValid_o slot", instValid_o[i], 1'b1);
        compare_value("inst_o slot", inst_o[i], model_word({tag, idx}, slot[1:0]));
      end
      else
        compare_value("instValid_o slot", instValid_o[i], 1'b0);
    end
    @(posedge clk);
    fetchReq_i <= 1'b0;
  endtask

  task automatic invalidate_line(input ic_index_t idx, input ic_way_t way);
    @(posedge clk);
    mem2icInv_i    <= 1'b1;
    mem2icInvInd_i <= idx;
    mem2icInvWay_i <= way;
    @(posedge clk);
    mem2icInv_i <= 1'b0;
    exp_valid[idx][way] = 1'b0;
  endtask

  task automatic flush_cache();
    @(posedge clk);
    icFlush_i <= 1'b1;
    @(negedge clk);
    compare_value("icFlushDone_o", icFlushDone_o, 1'b0);
    @(posedge clk);
    icFlush_i <= 1'b0;
    @(negedge clk);
    compare_value("icFlushDone_o", icFlushDone_o, 1'b1);
    @(negedge clk);
    compare_value("icFlushDone_o", icFlushDone_o, 1'b0);
    for (int s = 0; s < `ICACHE_NUM_LINES; s++)
    begin
      exp_valid[s][0] = 1'b0;
      exp_valid[s][1] = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    reset             = 1'b1;
    fetchReq_i        = 1'b0;
    pc_i              = '0;
    mem2icTag_i       = '0;
    mem2icIndex_i     = '0;
    mem2icData_i      = '0;
    mem2icRespValid_i = 1'b0;
    mem2icInv_i       = 1'b0;
    mem2icInvInd_i    = '0;
    mem2icInvWay_i    = '0;
    icFlush_i         = 1'b0;
    cycle             = 0;
    req_count         = 0;
    miss_count        = 0;
    resp_edge         = 0;
    good_resp_sent    = 1'b0;
    send_bad          = 1'b0;
    for (int s = 0; s < `ICACHE_NUM_LINES; s++)
    begin
      exp_valid[s][0] = 1'b0;
      exp_valid[s][1] = 1'b0;
      exp_tag[s][0]   = '0;
      exp_tag[s][1]   = '0;
      exp_rr[s]       = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // cold miss, then every offset of the filled line
    fetch_pc(make_pc(22'h0a1b2, 6'd3, 2'd0));
    for (int o = 1; o < `ICACHE_INSTS_IN_LINE; o++)
      fetch_pc(make_pc(22'h0a1b2, 6'd3, ic_offset_t'(o)));

    // three tags in set 5 where the third one evicts way 0
    fetch_pc(make_pc(22'h00011, 6'd5, 2'd0));
    fetch_pc(make_pc(22'h00022, 6'd5, 2'd1));
    fetch_pc(make_pc(22'h00011, 6'd5, 2'd2));
    fetch_pc(make_pc(22'h00022, 6'd5, 2'd3));
    fetch_pc(make_pc(22'h00033, 6'd5, 2'd0));
    fetch_pc(make_pc(22'h00022, 6'd5, 2'd0));
    fetch_pc(make_pc(22'h00011, 6'd5, 2'd1));

    // wrong tag and wrong index responses are ignored
    send_bad = 1'b1;
    fetch_pc(make_pc(22'h2f00d, 6'd9, 2'd1));
    require(!send_bad, "memory model never sent the bad responses");
    fetch_pc(make_pc(22'h2f00d, 6'd9, 2'd2));

    // single-line invalidation in set 12
    fetch_pc(make_pc(22'h10001, 6'd12, 2'd0));
    fetch_pc(make_pc(22'h10002, 6'd12, 2'd0));
    invalidate_line(6'd12, exp_tag[12][0] == 22'h10001 ? ic_way_t'(0) : ic_way_t'(1));
    fetch_pc(make_pc(22'h10002, 6'd12, 2'd2));
    fetch_pc(make_pc(22'h10001, 6'd12, 2'd3));

    // flush so that earlier hits miss again
    flush_cache();
    fetch_pc(make_pc(22'h0a1b2, 6'd3, 2'd0));
    fetch_pc(make_pc(22'h00022, 6'd5, 2'd1));
    fetch_pc(make_pc(22'h2f00d, 6'd9, 2'd0));
    fetch_pc(make_pc(22'h10001, 6'd12, 2'd2));

    repeat (4) @(posedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
icache_addr_pkg.sv
icache_line_pkg.sv
line_store.sv
valid_bits.sv
way_lookup.sv
miss_handler.sv
icache_top.sv
tb_icache_top.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - icache_addr_pkg.sv
      - icache_line_pkg.sv
      - line_store.sv
      - valid_bits.sv
      - way_lookup.sv
      - miss_handler.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_icache_top.sv
